//--- common/nfifo_pkg.sv
`default_nettype none

// ------------------------------------------------------------------------
// Default configuration of the multi-flow buffer
// ------------------------------------------------------------------------
package nfifo_pkg;

    // Number of write flows merged into the read port
    localparam int DEF_FLOWS = 4;

    // Width of one flow word
    localparam int DEF_FLOW_WIDTH = 16;

    // Words per flow block, power of two
    localparam int DEF_BLOCK_SIZE = 8;

    // Extra output register on the read path, 0 or 1
    localparam int DEF_OUTPUT_REG = 0;

    // ------------------------------------------------------------------------
    // Vectors sized to the default configuration
    // ------------------------------------------------------------------------

    // One flow word
    typedef logic [DEF_FLOW_WIDTH-1:0] flow_word_t;

    // Block or flow number
    typedef logic [$clog2(DEF_FLOWS)-1:0] flow_sel_t;

    // Fill level of one flow, 0 up to BLOCK_SIZE
    typedef logic [$clog2(DEF_BLOCK_SIZE+1)-1:0] level_t;

    // One bit per flow
    typedef logic [DEF_FLOWS-1:0] flow_mask_t;

endpackage : nfifo_pkg

`default_nettype wire

//--- common/nfifo_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// Per-flow write path from write control into the banked memory
interface nfifo_wr_if #(
    parameter int FLOWS      = 4,
    parameter int FLOW_WIDTH = 16,
    parameter int BLOCK_SIZE = 8
);

    // Word address inside one block
    localparam int ADDR_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;

    // One enable per flow, each flow owns its bank
    logic [FLOWS-1:0]                 we;
    logic [FLOWS-1:0][ADDR_W-1:0]     addr;
    logic [FLOWS-1:0][FLOW_WIDTH-1:0] data;

    // Write control side
    modport src (output we, output addr, output data);

    // Memory side
    modport dst (input we, input addr, input data);

endinterface : nfifo_wr_if

`default_nettype wire

//--- common/nfifo_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Read request and returned data between read control and memory
interface nfifo_rd_if #(
    parameter int FLOWS      = 4,
    parameter int FLOW_WIDTH = 16,
    parameter int BLOCK_SIZE = 8
);

    localparam int SEL_W  = (FLOWS > 1) ? $clog2(FLOWS) : 1;
    localparam int ADDR_W = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;

    logic                  en;       // accepted read this cycle
    logic [SEL_W-1:0]      block;    // bank to read
    logic [ADDR_W-1:0]     addr;     // word inside the bank
    logic                  advance;  // read pipeline may move
    logic [FLOW_WIDTH-1:0] data;     // word from the last stage

    // Read control side
    modport src (output en, output block, output addr, output advance, input data);

    // Memory side
    modport dst (input en, input block, input addr, input advance, output data);

endinterface : nfifo_rd_if

`default_nettype wire

//--- nfifo/nfifo_wr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo_wr_ctrl #(
    parameter int FLOWS      = 4,
    parameter int FLOW_WIDTH = 16,
    parameter int BLOCK_SIZE = 8
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire [FLOWS*FLOW_WIDTH-1:0]   data_in,
    input  wire [FLOWS-1:0]              write,
    input  wire [FLOWS-1:0]              full,
    output logic [FLOWS-1:0]             accepted,
    nfifo_wr_if.src                      wr
);

    localparam int ADDR_W     = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;

    // Next free slot of every flow block
    logic [FLOWS-1:0][ADDR_W-1:0] wr_ptr;

    // ------------------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------------------

    // Drop writes into a full block
    assign accepted = write & ~full;
    assign wr.we    = accepted;
    assign wr.addr  = wr_ptr;

    // Each flow owns one slice of the wide input word
    for (genvar f = 0; f < FLOWS; f++) begin : g_slice
        assign wr.data[f] = data_in[f*FLOW_WIDTH +: FLOW_WIDTH];
    end

    // ------------------------------------------------------------------------
    // Write pointers
    // ------------------------------------------------------------------------

    // Advance on the same edge that stores the word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else begin
            for (int f = 0; f < FLOWS; f++) begin
                if (accepted[f]) begin
                    // Wrap at the end of the block
                    if (wr_ptr[f] == ADDR_W'(BLOCK_SIZE - 1))
                        wr_ptr[f] <= '0;
                    else
                        wr_ptr[f] <= wr_ptr[f] + 1'b1;
                end
            end
        end
    end

endmodule : nfifo_wr_ctrl

`default_nettype wire

//--- nfifo/nfifo_status.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo_status #(
    parameter int FLOWS      = 4,
    parameter int BLOCK_SIZE = 8
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire [FLOWS-1:0]                               accepted,
    input  wire                                           pop,
    input  wire [((FLOWS > 1) ? $clog2(FLOWS) : 1)-1:0]   pop_flow,
    output logic [FLOWS-1:0]                              full,
    output logic [FLOWS-1:0]                              empty,
    output logic [FLOWS*$clog2(BLOCK_SIZE+1)-1:0]         status
);

    localparam int LEVEL_W = $clog2(BLOCK_SIZE + 1);

    // Current and next fill level of each flow
    logic [FLOWS-1:0][LEVEL_W-1:0] level_q;
    logic [FLOWS-1:0][LEVEL_W-1:0] level_d;

    // ------------------------------------------------------------------------
    // Next level
    // ------------------------------------------------------------------------

    always_comb begin
        for (int f = 0; f < FLOWS; f++) begin
            level_d[f] = level_q[f];
            // Push and pop together keep the level
            if (accepted[f] && !(pop && pop_flow == f))
                level_d[f] = level_q[f] + 1'b1;
            else if (!accepted[f] && pop && pop_flow == f)
                level_d[f] = level_q[f] - 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Counters and flags
    // ------------------------------------------------------------------------

    // Flags follow the new level on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_q <= '0;
            full    <= '0;
            empty   <= '1;
        end else begin
            level_q <= level_d;
            for (int f = 0; f < FLOWS; f++) begin
                full[f]  <= (level_d[f] == LEVEL_W'(BLOCK_SIZE));
                empty[f] <= (level_d[f] == '0);
            end
        end
    end

    // Flow 0 in the low bits
    assign status = level_q;

endmodule : nfifo_status

`default_nettype wire

//--- nfifo/nfifo_buffer_mem.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo_buffer_mem #(
    parameter int FLOWS      = 4,
    parameter int FLOW_WIDTH = 16,
    parameter int BLOCK_SIZE = 8,
    parameter int OUTPUT_REG = 0
) (
    input  wire      clk,
    nfifo_wr_if.dst  wr,
    nfifo_rd_if.dst  rd
);

    // One bank of BLOCK_SIZE words per flow
    logic [FLOW_WIDTH-1:0] mem [FLOWS][BLOCK_SIZE];

    // First read stage
    logic [FLOW_WIDTH-1:0] rd_data_q;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------

    // All banks may be written in the same cycle
    always_ff @(posedge clk) begin
        for (int f = 0; f < FLOWS; f++) begin
            if (wr.we[f])
                mem[f][wr.addr[f]] <= wr.data[f];
        end
    end

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    // Registered read, stalls with the pipeline
    always_ff @(posedge clk) begin
        if (rd.advance && rd.en)
            rd_data_q <= mem[rd.block][rd.addr];
    end

    if (OUTPUT_REG != 0) begin : g_out_reg
        // Extra stage for timing
        logic [FLOW_WIDTH-1:0] out_q;

        always_ff @(posedge clk) begin
            if (rd.advance)
                out_q <= rd_data_q;
        end

        assign rd.data = out_q;
    end else begin : g_no_out_reg
        // Data straight from the first stage
        assign rd.data = rd_data_q;
    end

endmodule : nfifo_buffer_mem

`default_nettype wire

//--- nfifo/nfifo_rd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo_rd_ctrl #(
    parameter int FLOWS      = 4,
    parameter int FLOW_WIDTH = 16,
    parameter int BLOCK_SIZE = 8,
    parameter int OUTPUT_REG = 0
) (
    input  wire                                           clk,
    input  wire                                           rst_n,
    input  wire                                           read,
    input  wire [((FLOWS > 1) ? $clog2(FLOWS) : 1)-1:0]   block_addr,
    input  wire                                           pipe_en,
    input  wire [FLOWS-1:0]                               empty,
    output logic                                          pop,
    output logic [((FLOWS > 1) ? $clog2(FLOWS) : 1)-1:0]  pop_flow,
    output logic [FLOW_WIDTH-1:0]                         data_out,
    output logic                                          data_vld,
    nfifo_rd_if.src                                       rd
);

    localparam int ADDR_W    = (BLOCK_SIZE > 1) ? $clog2(BLOCK_SIZE) : 1;
    // Valid chain matches the memory read depth
    localparam int VLD_DEPTH = (OUTPUT_REG != 0) ? 2 : 1;

    // Oldest word of every flow block
    logic [FLOWS-1:0][ADDR_W-1:0] rd_ptr;

    // Read marker travelling next to the data
    logic [VLD_DEPTH-1:0] vld_q;

    // ------------------------------------------------------------------------
    // Read acceptance
    // ------------------------------------------------------------------------

    // No read while stalled or from an empty block
    assign pop      = read && pipe_en && !empty[block_addr];
    assign pop_flow = block_addr;

    // Request goes to memory in the same cycle
    assign rd.en      = pop;
    assign rd.block   = block_addr;
    assign rd.addr    = rd_ptr[block_addr];
    assign rd.advance = pipe_en;

    // ------------------------------------------------------------------------
    // Read pointers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (pop) begin
            // Wrap at the end of the block
            if (rd_ptr[block_addr] == ADDR_W'(BLOCK_SIZE - 1))
                rd_ptr[block_addr] <= '0;
            else
                rd_ptr[block_addr] <= rd_ptr[block_addr] + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Data valid pipeline
    // ------------------------------------------------------------------------

    // Shifts only on enabled cycles, holds otherwise
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (pipe_en) begin
            vld_q[0] <= pop;
            for (int s = 1; s < VLD_DEPTH; s++)
                vld_q[s] <= vld_q[s-1];
        end
    end

    // Last stage lines up with the returned word
    assign data_vld = vld_q[VLD_DEPTH-1];
    assign data_out = rd.data;

endmodule : nfifo_rd_ctrl

`default_nettype wire

//--- design/nfifo2fifo.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo2fifo #(
    parameter int FLOWS      = nfifo_pkg::DEF_FLOWS,
    parameter int FLOW_WIDTH = nfifo_pkg::DEF_FLOW_WIDTH,
    parameter int BLOCK_SIZE = nfifo_pkg::DEF_BLOCK_SIZE,
    parameter int OUTPUT_REG = nfifo_pkg::DEF_OUTPUT_REG
) (
    input  wire                                           clk,
    input  wire                                           rst_n,

    // Write side, one slice and one strobe per flow
    input  wire [FLOWS*FLOW_WIDTH-1:0]                    data_in,
    input  wire [FLOWS-1:0]                               write,
    output logic [FLOWS-1:0]                              full,

    // Read side
    output logic [FLOW_WIDTH-1:0]                         data_out,
    output logic                                          data_vld,
    input  wire [((FLOWS > 1) ? $clog2(FLOWS) : 1)-1:0]   block_addr,
    input  wire                                           read,
    input  wire                                           pipe_en,
    output logic [FLOWS-1:0]                              empty,

    // Packed fill levels, flow 0 lowest
    output logic [FLOWS*$clog2(BLOCK_SIZE+1)-1:0]         status
);

    localparam int SEL_W = (FLOWS > 1) ? $clog2(FLOWS) : 1;

    // ------------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------------

    // Writes taken this cycle
    logic [FLOWS-1:0] accepted;

    // Read taken this cycle and its flow
    logic             pop;
    logic [SEL_W-1:0] pop_flow;

    nfifo_wr_if #(
        .FLOWS      (FLOWS),
        .FLOW_WIDTH (FLOW_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) wr_bus ();

    nfifo_rd_if #(
        .FLOWS      (FLOWS),
        .FLOW_WIDTH (FLOW_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) rd_bus ();

    // ------------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------------

    // Write decode and pointers
    nfifo_wr_ctrl #(
        .FLOWS      (FLOWS),
        .FLOW_WIDTH (FLOW_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_wr_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .data_in  (data_in),
        .write    (write),
        .full     (full),
        .accepted (accepted),
        .wr       (wr_bus.src)
    );

    // Fill counters and flags
    nfifo_status #(
        .FLOWS      (FLOWS),
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_status (
        .clk      (clk),
        .rst_n    (rst_n),
        .accepted (accepted),
        .pop      (pop),
        .pop_flow (pop_flow),
        .full     (full),
        .empty    (empty),
        .status   (status)
    );

    // Banked storage
    nfifo_buffer_mem #(
        .FLOWS      (FLOWS),
        .FLOW_WIDTH (FLOW_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE),
        .OUTPUT_REG (OUTPUT_REG)
    ) u_buffer_mem (
        .clk (clk),
        .wr  (wr_bus.dst),
        .rd  (rd_bus.dst)
    );

    // Read acceptance and valid pipeline
    nfifo_rd_ctrl #(
        .FLOWS      (FLOWS),
        .FLOW_WIDTH (FLOW_WIDTH),
        .BLOCK_SIZE (BLOCK_SIZE),
        .OUTPUT_REG (OUTPUT_REG)
    ) u_rd_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .read       (read),
        .block_addr (block_addr),
        .pipe_en    (pipe_en),
        .empty      (empty),
        .pop        (pop),
        .pop_flow   (pop_flow),
        .data_out   (data_out),
        .data_vld   (data_vld),
        .rd         (rd_bus.src)
    );

endmodule : nfifo2fifo

`default_nettype wire

//--- tests/nfifo2fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module nfifo2fifo_tb;

    localparam int FLOWS   = nfifo_pkg::DEF_FLOWS;
    localparam int FW      = nfifo_pkg::DEF_FLOW_WIDTH;
    localparam int BLOCK   = nfifo_pkg::DEF_BLOCK_SIZE;
    localparam int LEVEL_W = $bits(nfifo_pkg::level_t);
    // Enabled edges from an accepted read to data_vld
    localparam int VLD_DEPTH = (nfifo_pkg::DEF_OUTPUT_REG != 0) ? 2 : 1;
    // Enabled cycles allowed for the read pipeline to empty
    localparam int DRAIN_TIMEOUT = 20;

    // One table row, masks are the expected values after the step
    typedef struct {
        nfifo_pkg::flow_mask_t wr;
        logic                  rd;
        nfifo_pkg::flow_sel_t  addr;
        logic                  pe;
        nfifo_pkg::flow_mask_t full;
        nfifo_pkg::flow_mask_t empty;
    } step_t;

    logic                     clk;
    logic                     rst_n;
    logic [FLOWS*FW-1:0]      data_in;
    nfifo_pkg::flow_mask_t    write;
    nfifo_pkg::flow_mask_t    full;
    nfifo_pkg::flow_word_t    data_out;
    logic                     data_vld;
    nfifo_pkg::flow_sel_t     block_addr;
    logic                     read;
    logic                     pipe_en;
    nfifo_pkg::flow_mask_t    empty;
    logic [FLOWS*LEVEL_W-1:0] status;

    integer                seed = 32'h5fc2441d;
    step_t                 steps[$];
    nfifo_pkg::flow_word_t ref_q[FLOWS][$];  // reference contents per flow
    nfifo_pkg::flow_word_t out_q[$];         // popped words still in flight
    nfifo_pkg::flow_word_t prev_data;
    logic [VLD_DEPTH-1:0]  exp_vld;           // accepted reads moving toward data_vld

    nfifo2fifo #(
        .FLOWS      (nfifo_pkg::DEF_FLOWS),
        .FLOW_WIDTH (nfifo_pkg::DEF_FLOW_WIDTH),
        .BLOCK_SIZE (nfifo_pkg::DEF_BLOCK_SIZE),
        .OUTPUT_REG (nfifo_pkg::DEF_OUTPUT_REG)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .data_in    (data_in),
        .write      (write),
        .full       (full),
        .data_out   (data_out),
        .data_vld   (data_vld),
        .block_addr (block_addr),
        .read       (read),
        .pipe_en    (pipe_en),
        .empty      (empty),
        .status     (status)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------------

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare_word(input string name, input nfifo_pkg::flow_word_t got,
                                input nfifo_pkg::flow_word_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_level(input string name, input nfifo_pkg::level_t got,
                                 input nfifo_pkg::level_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_mask(input string name, input nfifo_pkg::flow_mask_t got,
                                input nfifo_pkg::flow_mask_t exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus and reference model
    // ------------------------------------------------------------------------

    task automatic add_step(input nfifo_pkg::flow_mask_t wr, input logic rd,
                            input nfifo_pkg::flow_sel_t addr, input logic pe,
                            input nfifo_pkg::flow_mask_t exp_full,
                            input nfifo_pkg::flow_mask_t exp_empty);
        step_t s;
        s.wr    = wr;
        s.rd    = rd;
        s.addr  = addr;
        s.pe    = pe;
        s.full  = exp_full;
        s.empty = exp_empty;
        steps.push_back(s);
    endtask

    task automatic load_steps();
        // Empty read, then fill all flows
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b1111);
        add_step(4'b1111, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1111, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b0101, 0, 0, 1, 4'b0000, 4'b0000);
        // One read from each block
        add_step(4'b0000, 1, 2, 1, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 1, 1, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 3, 1, 4'b0000, 4'b0000);
        // Flow 3 up to BLOCK_SIZE words
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b1000, 0, 0, 1, 4'b1000, 4'b0000);
        // Dropped writes into full flow 3
        add_step(4'b1001, 0, 0, 1, 4'b1000, 4'b0000);
        add_step(4'b1000, 1, 3, 1, 4'b0000, 4'b0000);
        // Write and read of one flow together
        add_step(4'b1000, 1, 3, 1, 4'b0000, 4'b0000);
        // Stall with pipe_en low
        add_step(4'b0000, 1, 0, 0, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 1, 0, 4'b0000, 4'b0000);
        add_step(4'b0010, 0, 1, 0, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 1, 1, 4'b0000, 4'b0000);
        // Empty flow 2, then read it once more
        add_step(4'b0000, 1, 2, 1, 4'b0000, 4'b0000);
        add_step(4'b0000, 1, 2, 1, 4'b0000, 4'b0100);
        add_step(4'b0001, 1, 2, 1, 4'b0000, 4'b0100);
        add_step(4'b0000, 1, 1, 1, 4'b0000, 4'b0110);
        // Wrapped flow 3 with a stall in between
        add_step(4'b0000, 1, 3, 1, 4'b0000, 4'b0110);
        add_step(4'b0000, 1, 3, 0, 4'b0000, 4'b0110);
        add_step(4'b0000, 1, 3, 1, 4'b0000, 4'b0110);
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b0110);
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b0110);
        add_step(4'b0000, 1, 0, 1, 4'b0000, 4'b0111);
    endtask

    // One enabled edge of the read pipeline
    task automatic shift_vld(input logic pop_now);
        for (int s = VLD_DEPTH - 1; s > 0; s--)
            exp_vld[s] = exp_vld[s-1];
        exp_vld[0] = pop_now;
    endtask

    task automatic drive_step(input step_t s);
        nfifo_pkg::flow_word_t word;
        logic                  take_rd;
        // Decided on the levels before the edge
        take_rd    = s.rd && s.pe && (ref_q[s.addr].size() != 0);
        write      = s.wr;
        read       = s.rd;
        block_addr = s.addr;
        pipe_en    = s.pe;
        for (int f = 0; f < FLOWS; f++) begin
            word = $random(seed);
            data_in[f*FW +: FW] = word;
            // Full block drops the word
            if (s.wr[f] && ref_q[f].size() < BLOCK)
                ref_q[f].push_back(word);
        end
        if (take_rd)
            out_q.push_back(ref_q[s.addr].pop_front());
        // Stalled edges leave the read pipeline alone
        if (s.pe)
            shift_vld(take_rd);
    endtask

    // pe is the pipe_en seen by the edge just passed
    task automatic check_step(input nfifo_pkg::flow_mask_t exp_full,
                              input nfifo_pkg::flow_mask_t exp_empty, input logic pe);
        compare_mask("full", full, exp_full);
        compare_mask("empty", empty, exp_empty);
        for (int f = 0; f < FLOWS; f++) begin
            compare_level($sformatf("status[%0d]", f), status[f*LEVEL_W +: LEVEL_W],
                          nfifo_pkg::level_t'(ref_q[f].size()));
        end
        compare_bit("data_vld", data_vld, exp_vld[VLD_DEPTH-1]);
        if (!pe) begin
            // Stalled output stage
            compare_word("data_out", data_out, prev_data);
        end else if (data_vld) begin
            compare_word("data_out", data_out, out_q.pop_front());
        end
        prev_data = data_out;
    endtask

    task automatic drain_reads(input nfifo_pkg::flow_mask_t exp_full,
                               input nfifo_pkg::flow_mask_t exp_empty);
        int waited;
        write   = '0;
        read    = 1'b0;
        pipe_en = 1'b1;
        waited  = 0;
        while (out_q.size() != 0) begin
            if (waited == DRAIN_TIMEOUT) begin
                $display("timed out waiting for data_vld, %0d reads never returned",
                         out_q.size());
                fail_run();
            end
            shift_vld(1'b0);
            @(negedge clk);
            check_step(exp_full, exp_empty, 1'b1);
            waited++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        step_t last;
        rst_n      = 1'b0;
        data_in    = '0;
        write      = '0;
        block_addr = '0;
        read       = 1'b0;
        pipe_en    = 1'b1;
        exp_vld    = '0;
        prev_data  = '0;
        load_steps();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // Reset values
        check_step('0, '1, 1'b1);
        foreach (steps[i]) begin
            drive_step(steps[i]);
            @(negedge clk);
            check_step(steps[i].full, steps[i].empty, steps[i].pe);
        end
        last = steps[steps.size()-1];
        drain_reads(last.full, last.empty);
        // No late data_vld once idle
        repeat (3) begin
            shift_vld(1'b0);
            @(negedge clk);
            check_step(last.full, last.empty, 1'b1);
        end
        $display("TEST OK");
        $finish;
    end

endmodule : nfifo2fifo_tb

`default_nettype wire

//--- nfifo2fifo.f
common/nfifo_pkg.sv
common/nfifo_wr_if.sv
common/nfifo_rd_if.sv
nfifo/nfifo_wr_ctrl.sv
nfifo/nfifo_status.sv
nfifo/nfifo_buffer_mem.sv
nfifo/nfifo_rd_ctrl.sv
design/nfifo2fifo.sv
tests/nfifo2fifo_tb.sv
